// File: Bender.yml
package:
  name: alu_credit_pipe

sources:
  - files:
      - src/alu_pkg.sv
      - src/flow_pkg.sv
      - src/alu_shifter.sv
      - src/alu_bitcount.sv
      - src/alu_execute.sv
      - src/alu_result_fifo.sv
      - src/alu_writeback.sv
      - src/alu_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/alu_tb.sv

// File: src/alu_bitcount.sv
// Leading zeros, trailing zeros and population count of operand a.
// CLZ and CTZ return XLEN for a zero operand; CPOP returns 0 for it.

`timescale 1ns/1ns

module alu_bitcount #(
  parameter int XLEN = 32
) (
  input  alu_pkg::alu_op_e       op_i,
  input  logic [XLEN-1:0]        operand_a_i,
  output logic [$clog2(XLEN):0]  count_o
);

  localparam int CW = $clog2(XLEN) + 1;

  logic [XLEN-1:0] lz_in;
  logic [CW-1:0]   lz_count;
  logic [CW-1:0]   pop_count;

  // CTZ counts leading zeros of the reversed operand
  always_comb begin
    for (int i = 0; i < XLEN; i++) begin
      lz_in[i] = (op_i == alu_pkg::CTZ) ? operand_a_i[XLEN-1-i] : operand_a_i[i];
    end
  end

  // Highest set bit wins, XLEN when none is set
  always_comb begin
    lz_count = CW'(XLEN);
    for (int i = 0; i < XLEN; i++) begin
      if (lz_in[i]) begin
        lz_count = CW'(XLEN - 1 - i);
      end
    end
  end

  always_comb begin
    pop_count = '0;
    for (int i = 0; i < XLEN; i++) begin
      pop_count = pop_count + CW'(operand_a_i[i]);
    end
  end

  assign count_o = (op_i == alu_pkg::CPOP) ? pop_count : lz_count;

endmodule

// File: src/alu_execute.sv
// Producer stage: computes one ALU operation and registers it, latency one cycle.
// The branch flag is the compare outcome for branch ops and one for all others.
// XLEN must be a power of two and a multiple of BYTE_WIDTH.

`timescale 1ns/1ns

module alu_execute #(
  parameter int XLEN = 32
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             op_valid_i,
  input  alu_pkg::alu_op_e op_i,
  input  logic [XLEN-1:0]  operand_a_i,
  input  logic [XLEN-1:0]  operand_b_i,
  output logic             exe_valid_o,
  output logic [XLEN-1:0]  exe_result_o,
  output logic             exe_branch_o
);

  localparam int BW = alu_pkg::BYTE_WIDTH;
  localparam int CW = $clog2(XLEN) + 1;

  logic            negate_b;
  logic [XLEN:0]   adder_in_a;
  logic [XLEN:0]   operand_b_neg;
  logic [XLEN:0]   adder_sum;
  logic [XLEN-1:0] adder_result;
  logic [XLEN-1:0] logic_b;
  logic            adder_zero;
  logic            sign_cmp;
  logic            less;
  logic [XLEN-1:0] shift_result;
  logic [CW-1:0]   count;
  logic [XLEN-1:0] orcb_res;
  logic [XLEN-1:0] rev8_res;
  logic [XLEN-1:0] result_d;
  logic            branch_d;

  // ------------------------------
  // Shared adder
  // ------------------------------
  // Extra low bit turns the inversion into a two's complement negate
  assign negate_b = op_i inside {alu_pkg::SUB, alu_pkg::EQ, alu_pkg::NE,
                                 alu_pkg::ANDN, alu_pkg::ORN, alu_pkg::XNOR};
  assign adder_in_a    = {operand_a_i, 1'b1};
  assign operand_b_neg = {operand_b_i, 1'b0} ^ {(XLEN + 1){negate_b}};
  assign adder_sum     = adder_in_a + operand_b_neg;
  assign adder_result  = adder_sum[XLEN:1];
  assign adder_zero    = ~|adder_result;
  assign logic_b       = operand_b_neg[XLEN:1];

  // Signed or unsigned less-than
  assign sign_cmp = op_i inside {alu_pkg::SLTS, alu_pkg::LTS, alu_pkg::GES,
                                 alu_pkg::MIN, alu_pkg::MAX};
  assign less = $signed({sign_cmp & operand_a_i[XLEN-1], operand_a_i}) <
                $signed({sign_cmp & operand_b_i[XLEN-1], operand_b_i});

  alu_shifter #(
    .XLEN (XLEN)
  ) u_shifter (
    .op_i           (op_i),
    .operand_a_i    (operand_a_i),
    .operand_b_i    (operand_b_i),
    .shift_result_o (shift_result)
  );

  alu_bitcount #(
    .XLEN (XLEN)
  ) u_bitcount (
    .op_i        (op_i),
    .operand_a_i (operand_a_i),
    .count_o     (count)
  );

  // Byte lanes
  for (genvar i = 0; i < XLEN / BW; i++) begin : g_byte
    assign orcb_res[i*BW +: BW] = {BW{|operand_a_i[i*BW +: BW]}};
    assign rev8_res[i*BW +: BW] = operand_a_i[XLEN-BW-i*BW +: BW];
  end

  // ------------------------------
  // Result mux and branch flag
  // ------------------------------
  always_comb begin
    case (op_i)
      alu_pkg::ADD, alu_pkg::SUB:   result_d = adder_result;
      alu_pkg::ANDL, alu_pkg::ANDN: result_d = operand_a_i & logic_b;
      alu_pkg::ORL, alu_pkg::ORN:   result_d = operand_a_i | logic_b;
      alu_pkg::XORL, alu_pkg::XNOR: result_d = operand_a_i ^ logic_b;
      alu_pkg::SLL, alu_pkg::SRL, alu_pkg::SRA,
      alu_pkg::ROL, alu_pkg::ROR:   result_d = shift_result;
      alu_pkg::SLTS, alu_pkg::SLTU: result_d = {{(XLEN-1){1'b0}}, less};
      alu_pkg::MIN, alu_pkg::MINU:  result_d = less ? operand_a_i : operand_b_i;
      alu_pkg::MAX, alu_pkg::MAXU:  result_d = less ? operand_b_i : operand_a_i;
      alu_pkg::CLZ, alu_pkg::CTZ,
      alu_pkg::CPOP:                result_d = {{(XLEN-CW){1'b0}}, count};
      alu_pkg::SEXTB: result_d = {{(XLEN-BW){operand_a_i[BW-1]}}, operand_a_i[BW-1:0]};
      alu_pkg::SEXTH: result_d = {{(XLEN-2*BW){operand_a_i[2*BW-1]}}, operand_a_i[2*BW-1:0]};
      alu_pkg::ZEXTH: result_d = {{(XLEN-2*BW){1'b0}}, operand_a_i[2*BW-1:0]};
      alu_pkg::ORCB:  result_d = orcb_res;
      alu_pkg::REV8:  result_d = rev8_res;
      // Branch compares give only the flag
      default:        result_d = '0;
    endcase
  end

  always_comb begin
    case (op_i)
      alu_pkg::EQ:                branch_d = adder_zero;
      alu_pkg::NE:                branch_d = ~adder_zero;
      alu_pkg::LTS, alu_pkg::LTU: branch_d = less;
      alu_pkg::GES, alu_pkg::GEU: branch_d = ~less;
      default:                    branch_d = 1'b1;
    endcase
  end

  // Output register
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exe_valid_o <= 1'b0;
    end else begin
      exe_valid_o <= op_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (op_valid_i) begin
      exe_result_o <= result_d;
      exe_branch_o <= branch_d;
    end
  end

endmodule

// File: src/alu_pkg.sv
// ALU opcode set and datapath width constants.
// The kept operation set has 33 entries, so the opcode needs six bits.
// Branch compare opcodes return a zero result and carry the outcome as a flag.

package alu_pkg;

  // Opcode width, wide enough for every kept operation
  localparam int OP_WIDTH = 6;

  // Lane width for byte-wise operations (ORCB, REV8, SEXTB)
  localparam int BYTE_WIDTH = 8;

  // ------------------------------
  // Operation encoding
  // ------------------------------
  typedef enum logic [OP_WIDTH-1:0] {
    // Adder
    ADD,
    SUB,
    // Logic, plain and inverted operand b
    ANDL,
    ORL,
    XORL,
    ANDN,
    ORN,
    XNOR,
    // Shifts and rotates
    SLL,
    SRL,
    SRA,
    ROL,
    ROR,
    // Set less than
    SLTS,
    SLTU,
    // Branch compares
    EQ,
    NE,
    LTS,
    LTU,
    GES,
    GEU,
    // Min and max
    MIN,
    MAX,
    MINU,
    MAXU,
    // Bit counting
    CLZ,
    CTZ,
    CPOP,
    // Extension and byte ops
    SEXTB,
    SEXTH,
    ZEXTH,
    ORCB,
    REV8
  } alu_op_e;

endpackage

// File: src/alu_result_fifo.sv
// Circular result buffer; each popped entry returns one issue credit on credit_o.
// FIFO_DEPTH may be 1 to 15. The issuer's credits guarantee a free slot on every push.

`timescale 1ns/1ns

module alu_result_fifo #(
  parameter int XLEN       = 32,
  parameter int FIFO_DEPTH = 4
) (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            push_i,
  input  logic [XLEN-1:0] push_result_i,
  input  logic            push_branch_i,
  input  logic            pop_i,
  output logic            valid_o,
  output logic [XLEN-1:0] result_o,
  output logic            branch_o,
  output logic            credit_o
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

  logic [XLEN-1:0]      mem_result [FIFO_DEPTH];
  logic                 mem_branch [FIFO_DEPTH];
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  flow_pkg::credit_cnt_t count;
  logic                 full;

  assign full     = (count == flow_pkg::credit_cnt_t'(FIFO_DEPTH));
  assign valid_o  = (count != '0);
  assign result_o = mem_result[rd_ptr];
  assign branch_o = mem_branch[rd_ptr];
  assign credit_o = pop_i;

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_result[wr_ptr] <= push_result_i;
      mem_branch[wr_ptr] <= push_branch_i;
    end
  end

  // Pointers wrap at FIFO_DEPTH, which need not be a power of two
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_i) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Issue credits reserve a slot for every op in flight
  a_no_push_full: assert property (@(posedge clk_i) disable iff (reset_i)
    push_i |-> !full)
    else $error("result FIFO pushed while full");

  // Writeback only pops a visible entry
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (reset_i)
    pop_i |-> valid_o)
    else $error("result FIFO popped while empty");

endmodule

// File: src/alu_shifter.sv
// Shifts and rotates on XLEN bits, shift amount taken from the low log2(XLEN) bits of b.
// XLEN must be a power of two.

`timescale 1ns/1ns

module alu_shifter #(
  parameter int XLEN = 32
) (
  input  alu_pkg::alu_op_e op_i,
  input  logic [XLEN-1:0]  operand_a_i,
  input  logic [XLEN-1:0]  operand_b_i,
  output logic [XLEN-1:0]  shift_result_o
);

  localparam int SHW = $clog2(XLEN);

  logic            shift_left;
  logic            shift_arith;
  logic [SHW-1:0]  shamt;
  logic [SHW:0]    back_amt;
  logic [XLEN-1:0] operand_a_rev;
  logic [XLEN-1:0] shift_in;
  logic [XLEN-1:0] shift_right_res;
  logic [XLEN-1:0] shift_left_res;
  logic [XLEN-1:0] back_right;
  logic [XLEN-1:0] back_left;

  assign shift_left  = op_i inside {alu_pkg::SLL, alu_pkg::ROL};
  assign shift_arith = (op_i == alu_pkg::SRA);
  assign shamt       = operand_b_i[SHW-1:0];

  // Left shifts run through the right shifter on a bit-reversed operand
  for (genvar i = 0; i < XLEN; i++) begin : g_rev
    assign operand_a_rev[i]  = operand_a_i[XLEN-1-i];
    assign shift_left_res[i] = shift_right_res[XLEN-1-i];
  end

  assign shift_in        = shift_left ? operand_a_rev : operand_a_i;
  assign shift_right_res = XLEN'($signed({shift_arith & shift_in[XLEN-1], shift_in})
                                 >>> shamt);

  // Wrapped-around part of a rotate, zero when shamt is zero
  assign back_amt   = (SHW+1)'(XLEN) - {1'b0, shamt};
  assign back_right = operand_a_i >> back_amt;
  assign back_left  = operand_a_i << back_amt;

  always_comb begin
    case (op_i)
      alu_pkg::SLL: shift_result_o = shift_left_res;
      alu_pkg::ROL: shift_result_o = shift_left_res | back_right;
      alu_pkg::ROR: shift_result_o = shift_right_res | back_left;
      default:      shift_result_o = shift_right_res;
    endcase
  end

endmodule

// File: src/alu_top.sv
// Credit-flow ALU pipeline, shortest op-to-result latency of three cycles.
// Issuer starts with FIFO_DEPTH credits, the DUT with OUT_CREDITS downstream.
// Both limits are at most 15.

`timescale 1ns/1ns

module alu_top #(
  parameter int XLEN        = 32,
  parameter int FIFO_DEPTH  = 4,
  parameter int OUT_CREDITS = 2
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             op_valid_i,
  input  alu_pkg::alu_op_e op_i,
  input  logic [XLEN-1:0]  operand_a_i,
  input  logic [XLEN-1:0]  operand_b_i,
  output logic             op_credit_o,
  output logic             result_valid_o,
  output logic [XLEN-1:0]  result_o,
  output logic             branch_taken_o,
  input  logic             result_credit_i
);

  logic            exe_valid;
  logic [XLEN-1:0] exe_result;
  logic            exe_branch;
  logic            fifo_valid;
  logic [XLEN-1:0] fifo_result;
  logic            fifo_branch;
  logic            fifo_pop;

  alu_execute #(
    .XLEN (XLEN)
  ) u_execute (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .op_valid_i   (op_valid_i),
    .op_i         (op_i),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .exe_valid_o  (exe_valid),
    .exe_result_o (exe_result),
    .exe_branch_o (exe_branch)
  );

  alu_result_fifo #(
    .XLEN       (XLEN),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_result_fifo (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .push_i        (exe_valid),
    .push_result_i (exe_result),
    .push_branch_i (exe_branch),
    .pop_i         (fifo_pop),
    .valid_o       (fifo_valid),
    .result_o      (fifo_result),
    .branch_o      (fifo_branch),
    .credit_o      (op_credit_o)
  );

  alu_writeback #(
    .XLEN        (XLEN),
    .OUT_CREDITS (OUT_CREDITS)
  ) u_writeback (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .valid_i        (fifo_valid),
    .result_i       (fifo_result),
    .branch_i       (fifo_branch),
    .credit_i       (result_credit_i),
    .pop_o          (fifo_pop),
    .result_valid_o (result_valid_o),
    .result_o       (result_o),
    .branch_taken_o (branch_taken_o)
  );

endmodule

// File: src/alu_writeback.sv
// Consumer stage: sends one result per downstream credit, as a one-cycle pulse.
// OUT_CREDITS may be 1 to 15; the receiver never returns more than it was given.

`timescale 1ns/1ns

module alu_writeback #(
  parameter int XLEN        = 32,
  parameter int OUT_CREDITS = 2
) (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            valid_i,
  input  logic [XLEN-1:0] result_i,
  input  logic            branch_i,
  input  logic            credit_i,
  output logic            pop_o,
  output logic            result_valid_o,
  output logic [XLEN-1:0] result_o,
  output logic            branch_taken_o
);

  flow_pkg::credit_cnt_t credit_cnt;

  // Pop and send together, only with a credit in hand
  assign pop_o = valid_i & (credit_cnt != '0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credit_cnt     <= flow_pkg::credit_cnt_t'(OUT_CREDITS);
      result_valid_o <= 1'b0;
    end else begin
      result_valid_o <= pop_o;
      case ({credit_i, pop_o})
        2'b10:   credit_cnt <= credit_cnt + 1'b1;
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      result_o       <= result_i;
      branch_taken_o <= branch_i;
    end
  end

  // Receiver returns no more credits than it holds
  a_credit_bound: assert property (@(posedge clk_i) disable iff (reset_i)
    credit_cnt <= flow_pkg::credit_cnt_t'(OUT_CREDITS))
    else $error("downstream credit count above OUT_CREDITS");

endmodule

// File: src/flow_pkg.sv
// Credit counter definitions shared by the result FIFO and the writeback stage.
// A counter holds at most 15 credits, which bounds FIFO_DEPTH and OUT_CREDITS.

package flow_pkg;

  // Four bits cover 0 to 15 credits
  localparam int CREDIT_WIDTH = 4;

  // Credit or occupancy count
  typedef logic [CREDIT_WIDTH-1:0] credit_cnt_t;

endpackage

// File: include/alu_ref.svh
// Reference model of ALU results and branch flags.
// Include inside a module that defines XLEN; branch ops return a zero result.

`ifndef ALU_REF_SVH
`define ALU_REF_SVH

function automatic logic [XLEN-1:0] result_model(alu_pkg::alu_op_e op,
                                                 logic [XLEN-1:0] a,
                                                 logic [XLEN-1:0] b);
  int unsigned     sh;
  int              cnt;
  int              bw;
  logic [XLEN-1:0] r;
  bw  = alu_pkg::BYTE_WIDTH;
  sh  = b[$clog2(XLEN)-1:0];
  cnt = 0;
  r   = '0;
  case (op)
    alu_pkg::ADD:  r = a + b;
    alu_pkg::SUB:  r = a - b;
    alu_pkg::ANDL: r = a & b;
    alu_pkg::ORL:  r = a | b;
    alu_pkg::XORL: r = a ^ b;
    alu_pkg::ANDN: r = a & ~b;
    alu_pkg::ORN:  r = a | ~b;
    alu_pkg::XNOR: r = a ^ ~b;
    alu_pkg::SLL:  r = a << sh;
    alu_pkg::SRL:  r = a >> sh;
    alu_pkg::SRA:  r = $signed(a) >>> sh;
    alu_pkg::ROL:  r = (a << sh) | (a >> (XLEN - sh));
    alu_pkg::ROR:  r = (a >> sh) | (a << (XLEN - sh));
    alu_pkg::SLTS: r = XLEN'($signed(a) < $signed(b));
    alu_pkg::SLTU: r = XLEN'(a < b);
    alu_pkg::MIN:  r = ($signed(a) < $signed(b)) ? a : b;
    alu_pkg::MAX:  r = ($signed(a) < $signed(b)) ? b : a;
    alu_pkg::MINU: r = (a < b) ? a : b;
    alu_pkg::MAXU: r = (a < b) ? b : a;
    alu_pkg::CLZ: begin
      cnt = XLEN;
      for (int i = 0; i < XLEN; i++) begin
        if (a[i]) cnt = XLEN - 1 - i;
      end
      r = XLEN'(cnt);
    end
    alu_pkg::CTZ: begin
      cnt = XLEN;
      for (int i = XLEN - 1; i >= 0; i--) begin
        if (a[i]) cnt = i;
      end
      r = XLEN'(cnt);
    end
    alu_pkg::CPOP: begin
      for (int i = 0; i < XLEN; i++) begin
        cnt += a[i];
      end
      r = XLEN'(cnt);
    end
    alu_pkg::SEXTB: r = {{(XLEN-8){a[7]}}, a[7:0]};
    alu_pkg::SEXTH: r = {{(XLEN-16){a[15]}}, a[15:0]};
    alu_pkg::ZEXTH: r = {{(XLEN-16){1'b0}}, a[15:0]};
    alu_pkg::ORCB: begin
      for (int i = 0; i < XLEN / bw; i++) begin
        r[i*8 +: 8] = (|a[i*8 +: 8]) ? 8'hff : 8'h00;
      end
    end
    alu_pkg::REV8: begin
      for (int i = 0; i < XLEN / bw; i++) begin
        r[i*8 +: 8] = a[XLEN-8-i*8 +: 8];
      end
    end
    default: r = '0;
  endcase
  return r;
endfunction

function automatic logic branch_model(alu_pkg::alu_op_e op,
                                      logic [XLEN-1:0] a,
                                      logic [XLEN-1:0] b);
  case (op)
    alu_pkg::EQ:  return a == b;
    alu_pkg::NE:  return a != b;
    alu_pkg::LTS: return $signed(a) < $signed(b);
    alu_pkg::LTU: return a < b;
    alu_pkg::GES: return $signed(a) >= $signed(b);
    alu_pkg::GEU: return a >= b;
    default:      return 1'b1;
  endcase
endfunction

`endif

// File: verif/alu_tb.sv
// Testbench for the credit-flow ALU, XLEN 32, FIFO_DEPTH 4, OUT_CREDITS 2.
// Directed corner operands first, then one op per opcode, then random ops.
// Receiver withholds credits in random stretches to force back-pressure.

`timescale 1ns/1ns

module alu_tb;

  localparam int XLEN        = 32;
  localparam int FIFO_DEPTH  = 4;
  localparam int OUT_CREDITS = 2;
  localparam int MAX_OPS     = 1024;
  localparam int N_RANDOM    = 600;
  localparam int NUM_OPS     = int'(alu_pkg::REV8) + 1;

  `include "alu_ref.svh"

  logic             clk_i;
  logic             reset_i;
  logic             op_valid_i;
  alu_pkg::alu_op_e op_i;
  logic [XLEN-1:0]  operand_a_i;
  logic [XLEN-1:0]  operand_b_i;
  logic             op_credit_o;
  logic             result_valid_o;
  logic [XLEN-1:0]  result_o;
  logic             branch_taken_o;
  logic             result_credit_i;

  // Stimulus and expected values, indexed by issue order
  alu_pkg::alu_op_e stim_op    [MAX_OPS];
  logic [XLEN-1:0]  stim_a     [MAX_OPS];
  logic [XLEN-1:0]  stim_b     [MAX_OPS];
  logic [XLEN-1:0]  exp_result [MAX_OPS];
  logic             exp_branch [MAX_OPS];

  integer seed          = 32'hacfd_2647;
  int     stim_cnt      = 0;
  int     stim_idx      = 0;
  int     rd_idx        = 0;
  int     issue_credits = FIFO_DEPTH;
  int     credit_pulses = 0;
  int     rx_held       = 0;
  int     hold_left     = 0;
  logic   withhold      = 1'b0;
  logic   stim_ready    = 1'b0;
  int     cyc_cnt       = 0;
  int     timeout_limit = 0;

  alu_top #(
    .XLEN        (XLEN),
    .FIFO_DEPTH  (FIFO_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
  ) UUT (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .op_valid_i      (op_valid_i),
    .op_i            (op_i),
    .operand_a_i     (operand_a_i),
    .operand_b_i     (operand_b_i),
    .op_credit_o     (op_credit_o),
    .result_valid_o  (result_valid_o),
    .result_o        (result_o),
    .branch_taken_o  (branch_taken_o),
    .result_credit_i (result_credit_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic add_stim(input alu_pkg::alu_op_e op, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b);
    stim_op[stim_cnt]    = op;
    stim_a[stim_cnt]     = a;
    stim_b[stim_cnt]     = b;
    exp_result[stim_cnt] = result_model(op, a, b);
    exp_branch[stim_cnt] = branch_model(op, a, b);
    stim_cnt++;
  endtask

  // Zero counts, shift by 0 and 31, operands around the sign boundary
  task automatic load_corner_ops();
    alu_pkg::alu_op_e cnt_ops [3]  = '{alu_pkg::CLZ, alu_pkg::CTZ, alu_pkg::CPOP};
    alu_pkg::alu_op_e sh_ops  [5]  = '{alu_pkg::SLL, alu_pkg::SRL, alu_pkg::SRA,
                                      alu_pkg::ROL, alu_pkg::ROR};
    alu_pkg::alu_op_e cmp_ops [12] = '{alu_pkg::SLTS, alu_pkg::SLTU, alu_pkg::EQ,
                                      alu_pkg::NE, alu_pkg::LTS, alu_pkg::LTU,
                                      alu_pkg::GES, alu_pkg::GEU, alu_pkg::MIN,
                                      alu_pkg::MAX, alu_pkg::MINU, alu_pkg::MAXU};
    logic [XLEN-1:0]  cnt_a   [4]  = '{32'h0, 32'h1, 32'h8000_0000, 32'hffff_ffff};
    logic [XLEN-1:0]  sh_a    [2]  = '{32'h8000_0001, 32'h7f00_00fe};
    logic [XLEN-1:0]  pair_a  [5]  = '{32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff,
                                      32'h0, 32'h8000_0000};
    logic [XLEN-1:0]  pair_b  [5]  = '{32'h8000_0000, 32'h7fff_ffff, 32'h0,
                                      32'hffff_ffff, 32'h8000_0000};
    foreach (cnt_ops[i]) begin
      foreach (cnt_a[j]) begin
        add_stim(cnt_ops[i], cnt_a[j], 32'h0);
      end
    end
    foreach (sh_ops[i]) begin
      foreach (sh_a[j]) begin
        add_stim(sh_ops[i], sh_a[j], 32'd0);
        add_stim(sh_ops[i], sh_a[j], 32'd31);
      end
    end
    foreach (cmp_ops[i]) begin
      foreach (pair_a[j]) begin
        add_stim(cmp_ops[i], pair_a[j], pair_b[j]);
      end
    end
  endtask

  // ------------------------------
  // Issuer, spends one credit per op
  // ------------------------------
  always @(posedge clk_i) begin : issuer
    logic take;
    if (reset_i) begin
      op_valid_i    <= 1'b0;
      issue_credits <= FIFO_DEPTH;
    end else begin
      take = stim_ready && (issue_credits > 0) && (stim_idx < stim_cnt);
      op_valid_i <= take;
      if (take) begin
        op_i        <= stim_op[stim_idx];
        operand_a_i <= stim_a[stim_idx];
        operand_b_i <= stim_b[stim_idx];
        stim_idx    <= stim_idx + 1;
      end
      issue_credits <= issue_credits - int'(take) + int'(op_credit_o);
      if (op_credit_o) begin
        credit_pulses <= credit_pulses + 1;
      end
    end
  end

  // ------------------------------
  // Receiver with random back-pressure
  // ------------------------------
  always @(posedge clk_i) begin : receiver
    logic give;
    if (reset_i) begin
      result_credit_i <= 1'b0;
      rx_held         <= 0;
      hold_left       <= 0;
      withhold        <= 1'b0;
    end else begin
      give = !withhold && (rx_held > 0);
      result_credit_i <= give;
      rx_held         <= rx_held + int'(result_valid_o) - int'(give);
      if (hold_left == 0) begin
        withhold  <= $random(seed) & 1;
        hold_left <= (($random(seed) & 32'h7fff_ffff) % 24);
      end else begin
        hold_left <= hold_left - 1;
      end
      if (result_valid_o) begin
        rd_idx <= rd_idx + 1;
      end
    end
  end

  // Watchdog
  always @(posedge clk_i) begin
    cyc_cnt <= cyc_cnt + 1;
    if (stim_ready && cyc_cnt > timeout_limit) begin
      abort_run($sformatf("timeout after %0d cycles, %0d of %0d results received",
                          cyc_cnt, rd_idx, stim_cnt));
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------
  a_result_match: assert property (@(posedge clk_i) disable iff (reset_i)
    result_valid_o |-> result_o == exp_result[rd_idx])
    else abort_run($sformatf("[FAIL] %0t ns result_o expected %h actual %h", $time,
                             exp_result[$sampled(rd_idx)], $sampled(result_o)));

  a_branch_match: assert property (@(posedge clk_i) disable iff (reset_i)
    result_valid_o |-> branch_taken_o == exp_branch[rd_idx])
    else abort_run($sformatf("[FAIL] %0t ns branch_taken_o expected %b actual %b", $time,
                             exp_branch[$sampled(rd_idx)], $sampled(branch_taken_o)));

  a_result_expected: assert property (@(posedge clk_i) disable iff (reset_i)
    result_valid_o |-> rd_idx < stim_idx)
    else abort_run("a result came out with no op outstanding");

  // Receiver must have had a free slot for every result
  a_downstream_credit: assert property (@(posedge clk_i) disable iff (reset_i)
    result_valid_o |-> rx_held < OUT_CREDITS)
    else abort_run("a result was sent while the receiver held no free slot");

  a_issue_credit_bound: assert property (@(posedge clk_i) disable iff (reset_i)
    issue_credits <= FIFO_DEPTH)
    else abort_run("more issue credits came back than ops were issued");

  a_reset_no_result: assert property (@(posedge clk_i)
    (cyc_cnt > 0) && (reset_i || $past(reset_i)) |-> !result_valid_o)
    else abort_run($sformatf("[FAIL] %0t ns result_valid_o expected 0 actual %b", $time,
                             $sampled(result_valid_o)));

  a_reset_no_credit: assert property (@(posedge clk_i)
    (cyc_cnt > 0) && (reset_i || $past(reset_i)) |-> !op_credit_o)
    else abort_run($sformatf("[FAIL] %0t ns op_credit_o expected 0 actual %b", $time,
                             $sampled(op_credit_o)));

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    reset_i         = 1'b1;
    op_valid_i      = 1'b0;
    op_i            = alu_pkg::ADD;
    operand_a_i     = '0;
    operand_b_i     = '0;
    result_credit_i = 1'b0;

    load_corner_ops();
    for (int k = 0; k < NUM_OPS; k++) begin
      add_stim(alu_pkg::alu_op_e'(k), $random(seed), $random(seed));
    end
    for (int k = 0; k < N_RANDOM; k++) begin
      add_stim(alu_pkg::alu_op_e'(($random(seed) & 32'h7fff_ffff) % NUM_OPS),
               $random(seed), $random(seed));
    end
    timeout_limit = 4 * stim_cnt + 200;
    stim_ready    = 1'b1;

    repeat (10) @(posedge clk_i);
    reset_i <= 1'b0;

    while (rd_idx < stim_cnt) @(posedge clk_i);
    repeat (4) @(posedge clk_i);

    if (credit_pulses == rd_idx && rd_idx == stim_cnt && issue_credits == FIFO_DEPTH) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      abort_run($sformatf("credit totals differ: %0d credit pulses, %0d results, %0d ops",
                          credit_pulses, rd_idx, stim_cnt));
    end
  end

endmodule

// File: verilog.f
+incdir+include
src/alu_pkg.sv
src/flow_pkg.sv
src/alu_shifter.sv
src/alu_bitcount.sv
src/alu_execute.sv
src/alu_result_fifo.sv
src/alu_writeback.sv
src/alu_top.sv
verif/alu_tb.sv
